/* sim.f */
+incdir+tb
src/cpu_pkg.sv
src/pipe_reg.sv
src/alu.sv
src/reg_file.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/writeback_stage.sv
src/cpu_top.sv
tb/cpu_tb.sv

/* Makefile */
# Verilator build and run for the pipelined cpu

VERILATOR ?= verilator
TOP       ?= cpu_tb
BUILD_DIR ?= obj_dir
FILE_LIST ?= sim.f
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP BUILD_DIR FILE_LIST FLAGS"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* tb/test_program.svh */
// program image, expected WWD values and expected stores
localparam int n_out = 9;
localparam int n_st  = 3;
localparam int n_retired = 35; // includes hlt, excludes flushed and stalled slots

localparam word_t exp_out [n_out] = '{
	16'h1234, 16'h1233, 16'hffff, 16'ha004, 16'h10f3,
	16'h10f3, 16'h0007, 16'h10ec, 16'ha000
};
localparam word_t exp_st_addr [n_st] = '{16'h0020, 16'h0034, 16'h0017};
localparam word_t exp_st_data [n_st] = '{16'h10f3, 16'ha004, 16'h0007};

task automatic load_program();
	for (int a = 0; a < 256; a++)
		imem[a] = nop_inst;
	imem[0]  = imm_inst(op_lhi, 2'd0, 2'd1, 8'h12);
	imem[1]  = imm_inst(op_ori, 2'd1, 2'd1, 8'h34);
	imem[2]  = alu_inst(fn_wwd, 2'd1, 2'd0, 2'd0);
	imem[3]  = imm_inst(op_adi, 2'd0, 2'd2, 8'hff);
	imem[4]  = alu_inst(fn_add, 2'd1, 2'd2, 2'd3);
	imem[5]  = alu_inst(fn_wwd, 2'd3, 2'd0, 2'd0);
	imem[6]  = alu_inst(fn_sub, 2'd3, 2'd1, 2'd3);
	imem[7]  = alu_inst(fn_wwd, 2'd3, 2'd0, 2'd0);
	imem[8]  = imm_inst(op_ori, 2'd0, 2'd2, 8'h0f);
	imem[9]  = alu_inst(fn_and, 2'd1, 2'd2, 2'd2);
	imem[10] = imm_inst(op_lhi, 2'd0, 2'd3, 8'ha0);
	imem[11] = alu_inst(fn_orr, 2'd3, 2'd2, 2'd3);
	imem[12] = alu_inst(fn_wwd, 2'd3, 2'd0, 2'd0);
	imem[13] = imm_inst(op_lwd, 2'd0, 2'd1, 8'h10); // load-use pair
	imem[14] = alu_inst(fn_add, 2'd1, 2'd2, 2'd1);
	imem[15] = alu_inst(fn_wwd, 2'd1, 2'd0, 2'd0);
	imem[16] = imm_inst(op_swd, 2'd0, 2'd1, 8'h20);
	imem[17] = imm_inst(op_swd, 2'd2, 2'd3, 8'h30);
	imem[18] = imm_inst(op_lwd, 2'd2, 2'd0, 8'h1c); // reads back the first store
	imem[19] = alu_inst(fn_wwd, 2'd0, 2'd0, 2'd0);
	imem[20] = imm_inst(op_beq, 2'd0, 2'd1, 8'h02); // taken to 23
	imem[21] = alu_inst(fn_wwd, 2'd3, 2'd0, 2'd0);
	imem[22] = alu_inst(fn_wwd, 2'd2, 2'd0, 2'd0);
	imem[23] = imm_inst(op_adi, 2'd2, 2'd2, 8'h01);
	imem[24] = imm_inst(op_bne, 2'd2, 2'd3, 8'h01); // taken to 26
	imem[25] = alu_inst(fn_wwd, 2'd2, 2'd0, 2'd0);
	imem[26] = imm_inst(op_bne, 2'd0, 2'd1, 8'h01); // not taken
	imem[27] = imm_inst(op_adi, 2'd2, 2'd2, 8'h02);
	imem[28] = imm_inst(op_beq, 2'd2, 2'd2, 8'h00); // target is pc+1
	imem[29] = alu_inst(fn_wwd, 2'd2, 2'd0, 2'd0);
	imem[30] = imm_inst(op_swd, 2'd2, 2'd2, 8'h10);
	imem[31] = alu_inst(fn_sub, 2'd0, 2'd2, 2'd1);
	imem[32] = imm_inst(op_beq, 2'd1, 2'd0, 8'h01); // not taken
	imem[33] = alu_inst(fn_wwd, 2'd1, 2'd0, 2'd0);
	imem[34] = imm_inst(op_adi, 2'd3, 2'd3, 8'hfc);
	imem[35] = imm_inst(op_bne, 2'd3, 2'd1, 8'h01); // taken to 37
	imem[36] = alu_inst(fn_wwd, 2'd0, 2'd0, 2'd0);
	imem[37] = alu_inst(fn_wwd, 2'd3, 2'd0, 2'd0);
	imem[38] = alu_inst(fn_hlt, 2'd0, 2'd0, 2'd0);
endtask

/* tb/cpu_tb.sv */
module cpu_tb
	import cpu_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int max_cycles = 400;

	logic  clk = 1'b1;
	logic  arst_n = 1'b1;
	logic  i_read;
	word_t i_addr;
	word_t i_rdata;
	logic  d_read;
	logic  d_write;
	word_t d_addr;
	word_t d_wdata;
	word_t d_rdata;
	word_t output_port;
	word_t num_inst;
	logic  is_halted;

	word_t imem [256];
	word_t dmem [256];
	int    out_idx;
	int    st_idx;
	int    cycles = 0;
	logic  wwd_retire;

	function automatic word_t alu_inst(logic [fn_w-1:0] fn, reg_addr_t rs, reg_addr_t rt,
		reg_addr_t rd);
		return {op_alu, rs, rt, rd, fn};
	endfunction

	function automatic word_t imm_inst(opcode_t op, reg_addr_t rs, reg_addr_t rt,
		logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	`include "test_program.svh"

	task automatic stop_on_error(string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	cpu_top u_cpu_top (
		.clk(clk), .arst_n(arst_n),
		.i_read(i_read), .i_addr(i_addr), .i_rdata(i_rdata),
		.d_read(d_read), .d_write(d_write), .d_addr(d_addr), .d_wdata(d_wdata),
		.d_rdata(d_rdata),
		.output_port(output_port), .num_inst(num_inst), .is_halted(is_halted)
	);

	always #50 clk = ~clk;

	// memory models, reads are combinational
	assign i_rdata = imem[i_addr[7:0]];
	assign d_rdata = dmem[d_addr[7:0]];

	always @(posedge clk) begin
		if (d_write)
			dmem[d_addr[7:0]] <= d_wdata;
	end

	assign wwd_retire = u_cpu_top.mem_wb_q.valid && u_cpu_top.mem_wb_q.is_wwd;

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_idx <= 0;
			st_idx  <= 0;
		end else begin
			if (wwd_retire)
				out_idx <= out_idx + 1;
			if (d_write)
				st_idx <= st_idx + 1;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles)
			stop_on_error("timeout, the processor never raised is_halted");
	end

	a_reset_quiet: assert property (@(posedge clk) (!arst_n || $rose(arst_n)) |->
		!d_write && !is_halted && num_inst == 16'h0 && output_port == 16'h0)
		else stop_on_error($sformatf("[FAIL] reset d_write %h is_halted %h num_inst %h out %h",
			$sampled(d_write), $sampled(is_halted), $sampled(num_inst),
			$sampled(output_port)));

	a_reset_strobes: assert property (@(posedge clk) (!arst_n || $rose(arst_n)) |->
		i_read && !d_read)
		else stop_on_error($sformatf("[FAIL] reset i_read %h d_read %h",
			$sampled(i_read), $sampled(d_read)));

	a_out_count: assert property (@(posedge clk) disable iff (!arst_n)
		wwd_retire |-> out_idx < n_out)
		else stop_on_error("more WWD instructions retired than expected");

	a_out_value: assert property (@(posedge clk) disable iff (!arst_n)
		wwd_retire |=> output_port == exp_out[out_idx-1])
		else stop_on_error($sformatf("[FAIL] output_port got %h expected %h",
			$sampled(output_port), exp_out[$sampled(out_idx)-1]));

	a_store_count: assert property (@(posedge clk) disable iff (!arst_n)
		d_write |-> st_idx < n_st)
		else stop_on_error("more stores than expected");

	a_store_addr: assert property (@(posedge clk) disable iff (!arst_n)
		d_write |-> d_addr == exp_st_addr[st_idx])
		else stop_on_error($sformatf("[FAIL] d_addr got %h expected %h",
			$sampled(d_addr), exp_st_addr[$sampled(st_idx)]));

	a_store_data: assert property (@(posedge clk) disable iff (!arst_n)
		d_write |-> d_wdata == exp_st_data[st_idx])
		else stop_on_error($sformatf("[FAIL] d_wdata got %h expected %h",
			$sampled(d_wdata), exp_st_data[$sampled(st_idx)]));

	// hlt sits in writeback, its own count lands one edge later
	a_halt_count: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(is_halted) |-> num_inst == word_t'(n_retired - 1))
		else stop_on_error($sformatf("[FAIL] num_inst got %h expected %h",
			$sampled(num_inst), word_t'(n_retired - 1)));

	a_halt_output: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(is_halted) |-> output_port == exp_out[n_out-1])
		else stop_on_error($sformatf("[FAIL] output_port at halt got %h expected %h",
			$sampled(output_port), exp_out[n_out-1]));

	a_halt_complete: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(is_halted) |-> out_idx == n_out && st_idx == n_st)
		else stop_on_error("halted before all expected outputs and stores were seen");

	initial begin
		load_program();
		for (int a = 0; a < 256; a++)
			dmem[a] = {a[7:0], ~a[7:0]};
		@(negedge clk);
		arst_n = 1'b0;
		repeat (4) @(negedge clk);
		arst_n = 1'b1;
		wait (is_halted);
		@(posedge clk); // halt checks sample on this edge
		@(negedge clk);
		$display("TESTS PASSED");
		$finish;
	end

endmodule

/* src/cpu_top.sv */
module cpu_top
	import cpu_pkg::*;
(
	input  logic  clk,
	input  logic  arst_n,
	output logic  i_read,
	output word_t i_addr,
	input  word_t i_rdata,
	output logic  d_read,
	output logic  d_write,
	output word_t d_addr,
	output word_t d_wdata,
	input  word_t d_rdata,
	output word_t output_port,
	output word_t num_inst,
	output logic  is_halted
);
	word_t     pc;
	word_t     if_id_pc;
	word_t     if_id_inst;
	reg_addr_t rs;
	reg_addr_t rt;
	word_t     rs_data;
	word_t     rt_data;
	logic      load_stall;
	logic      redirect;
	word_t     wb_result;

	id_ex_t  id_ex_d, id_ex_q;
	ex_mem_t ex_mem_d, ex_mem_q;
	mem_wb_t mem_wb_d, mem_wb_q;

	assign i_read = 1'b1;
	assign i_addr = pc;

	// memory stage
	assign d_read   = ex_mem_q.mem_read;
	assign d_write  = ex_mem_q.mem_write;
	assign d_addr   = ex_mem_q.alu_result;
	assign d_wdata  = ex_mem_q.store_data;
	assign redirect = ex_mem_q.valid && ex_mem_q.branch_taken;

	assign mem_wb_d = '{
		alu_result: ex_mem_q.alu_result,
		load_data:  d_rdata,
		wwd_value:  ex_mem_q.wwd_value,
		dest:       ex_mem_q.dest,
		mem_to_reg: ex_mem_q.mem_read,
		reg_write:  ex_mem_q.reg_write,
		is_wwd:     ex_mem_q.is_wwd,
		is_hlt:     ex_mem_q.is_hlt,
		valid:      ex_mem_q.valid
	};

	fetch_stage u_fetch (
		.clk(clk), .arst_n(arst_n),
		.stall(load_stall), .redirect(redirect), .redirect_target(ex_mem_q.branch_target),
		.inst_in(i_rdata),
		.pc(pc), .if_id_pc(if_id_pc), .if_id_inst(if_id_inst)
	);

	decode_stage u_decode (
		.inst(if_id_inst), .pc(if_id_pc), .rs_data(rs_data), .rt_data(rt_data),
		.ex_dest(id_ex_q.dest), .ex_mem_read(id_ex_q.mem_read),
		.rs(rs), .rt(rt), .load_stall(load_stall), .payload(id_ex_d)
	);

	reg_file u_reg_file (
		.clk(clk), .arst_n(arst_n), .rs(rs), .rt(rt),
		.wr_en(mem_wb_q.reg_write), .wr_addr(mem_wb_q.dest), .wr_data(wb_result),
		.rs_data(rs_data), .rt_data(rt_data)
	);

	pipe_reg #(.payload_t(id_ex_t), .bubble(id_ex_bubble)) u_id_ex (
		.clk(clk), .arst_n(arst_n), .flush(load_stall || redirect), .hold(1'b0),
		.d(id_ex_d), .q(id_ex_q)
	);

	execute_stage u_execute (
		.ex(id_ex_q),
		.mem_dest(ex_mem_q.dest), .mem_reg_write(ex_mem_q.reg_write),
		.mem_result(ex_mem_q.alu_result),
		.wb_dest(mem_wb_q.dest), .wb_reg_write(mem_wb_q.reg_write), .wb_result(wb_result),
		.payload(ex_mem_d)
	);

	pipe_reg #(.payload_t(ex_mem_t), .bubble(ex_mem_bubble)) u_ex_mem (
		.clk(clk), .arst_n(arst_n), .flush(redirect), .hold(1'b0),
		.d(ex_mem_d), .q(ex_mem_q)
	);

	pipe_reg #(.payload_t(mem_wb_t), .bubble(mem_wb_bubble)) u_mem_wb (
		.clk(clk), .arst_n(arst_n), .flush(1'b0), .hold(1'b0),
		.d(mem_wb_d), .q(mem_wb_q)
	);

	writeback_stage u_writeback (
		.clk(clk), .arst_n(arst_n), .wb(mem_wb_q), .result(wb_result),
		.output_port(output_port), .num_inst(num_inst), .is_halted(is_halted)
	);

endmodule

/* src/writeback_stage.sv */
module writeback_stage
	import cpu_pkg::*;
(
	input  logic    clk,
	input  logic    arst_n,
	input  mem_wb_t wb,
	output word_t   result,
	output word_t   output_port,
	output word_t   num_inst,
	output logic    is_halted
);

	assign result    = wb.mem_to_reg ? wb.load_data : wb.alu_result;
	assign is_halted = wb.valid && wb.is_hlt;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			output_port <= '0;
		end else if (wb.valid && wb.is_wwd) begin
			output_port <= wb.wwd_value;
		end
	end

	// bubbles do not retire
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			num_inst <= '0;
		end else if (wb.valid) begin
			num_inst <= num_inst + word_t'(1);
		end
	end

endmodule

/* src/execute_stage.sv */
module execute_stage
	import cpu_pkg::*;
(
	input  id_ex_t    ex,
	input  reg_addr_t mem_dest,
	input  logic      mem_reg_write,
	input  word_t     mem_result,
	input  reg_addr_t wb_dest,
	input  logic      wb_reg_write,
	input  word_t     wb_result,
	output ex_mem_t   payload
);
	word_t op_a;
	word_t op_b;
	word_t fwd_b;
	word_t alu_result;
	word_t pc_plus_1;
	word_t target;
	logic  equal;

	// nearest producer first
	function automatic word_t forward(reg_addr_t src, word_t reg_val);
		if (mem_reg_write && mem_dest == src)
			return mem_result;
		if (wb_reg_write && wb_dest == src)
			return wb_result;
		return reg_val;
	endfunction

	assign op_a  = forward(ex.rs, ex.rs_data);
	assign fwd_b = forward(ex.rt, ex.rt_data);
	assign op_b  = ex.alu_src ? ex.imm : fwd_b;

	alu u_alu (.a(op_a), .b(op_b), .op(ex.alu_op), .equal(equal), .result(alu_result));

	assign pc_plus_1 = ex.pc + word_t'(1);
	assign target    = pc_plus_1 + ex.imm;

	always_comb begin
		payload               = ex_mem_bubble;
		payload.alu_result    = alu_result;
		payload.store_data    = fwd_b;
		payload.wwd_value     = op_a;
		payload.dest          = ex.dest;
		payload.branch_target = target;
		// a branch to pc+1 is a fall-through, nothing to flush
		payload.branch_taken  = ex.is_branch && (equal == ex.branch_on_eq) &&
			(target != pc_plus_1);
		payload.mem_read      = ex.mem_read;
		payload.mem_write     = ex.mem_write;
		payload.reg_write     = ex.reg_write;
		payload.is_wwd        = ex.is_wwd;
		payload.is_hlt        = ex.is_hlt;
		payload.valid         = ex.valid;
	end

endmodule

/* src/decode_stage.sv */
module decode_stage
	import cpu_pkg::*;
(
	input  word_t     inst,
	input  word_t     pc,
	input  word_t     rs_data,
	input  word_t     rt_data,
	input  reg_addr_t ex_dest,
	input  logic      ex_mem_read,
	output reg_addr_t rs,
	output reg_addr_t rt,
	output logic      load_stall,
	output id_ex_t    payload
);
	opcode_t          opcode;
	reg_addr_t        rd;
	logic [fn_w-1:0]  fn;
	logic [imm_w-1:0] imm;
	logic             reads_rs;
	logic             reads_rt;

	assign opcode = inst[op_lsb +: 4];
	assign rs     = inst[rs_lsb +: 2];
	assign rt     = inst[rt_lsb +: 2];
	assign rd     = inst[rd_lsb +: 2];
	assign fn     = inst[fn_w-1:0];
	assign imm    = inst[imm_w-1:0];

	always_comb begin
		payload         = id_ex_bubble;
		payload.pc      = pc;
		payload.rs      = rs;
		payload.rt      = rt;
		payload.rs_data = rs_data;
		payload.rt_data = rt_data;
		payload.imm     = {{(word_w-imm_w){imm[imm_w-1]}}, imm};
		payload.dest    = rt;
		payload.valid   = 1'b1;
		reads_rs        = 1'b1;
		reads_rt        = 1'b0;
		case (opcode)
			op_alu: begin
				payload.dest = rd;
				case (fn)
					fn_add: {payload.alu_op, payload.reg_write, reads_rt} = {alu_add, 2'b11};
					fn_sub: {payload.alu_op, payload.reg_write, reads_rt} = {alu_sub, 2'b11};
					fn_and: {payload.alu_op, payload.reg_write, reads_rt} = {alu_and, 2'b11};
					fn_orr: {payload.alu_op, payload.reg_write, reads_rt} = {alu_or, 2'b11};
					fn_wwd: payload.is_wwd = 1'b1;
					fn_hlt: {payload.is_hlt, reads_rs} = 2'b10;
					default: {payload.valid, reads_rs} = 2'b00;
				endcase
			end
			op_adi: {payload.alu_src, payload.reg_write} = 2'b11;
			op_ori, op_lhi: begin
				payload.imm       = {{(word_w-imm_w){1'b0}}, imm}; // zero-extended
				payload.alu_op    = (opcode == op_lhi) ? alu_lhi : alu_or;
				payload.alu_src   = 1'b1;
				payload.reg_write = 1'b1;
				reads_rs          = (opcode == op_ori);
			end
			op_lwd: {payload.alu_src, payload.mem_read, payload.reg_write} = 3'b111;
			op_swd: begin
				{payload.alu_src, payload.mem_write} = 2'b11;
				reads_rt = 1'b1;
			end
			op_beq, op_bne: begin
				payload.is_branch    = 1'b1;
				payload.branch_on_eq = (opcode == op_beq);
				reads_rt             = 1'b1;
			end
			default: {payload.valid, reads_rs} = 2'b00; // nop and unsupported opcodes
		endcase
	end

	// load in execute feeding a source read here
	assign load_stall = ex_mem_read &&
		((reads_rs && ex_dest == rs) || (reads_rt && ex_dest == rt));

endmodule

/* src/fetch_stage.sv */
module fetch_stage
	import cpu_pkg::*;
(
	input  logic  clk,
	input  logic  arst_n,
	input  logic  stall,
	input  logic  redirect,
	input  word_t redirect_target,
	input  word_t inst_in,
	output word_t pc,
	output word_t if_id_pc,
	output word_t if_id_inst
);

	// redirect wins over a load stall
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
		end else if (redirect) begin
			pc <= redirect_target;
		end else if (!stall) begin
			pc <= pc + word_t'(1);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			if_id_pc   <= '0;
			if_id_inst <= nop_inst;
		end else if (redirect) begin
			if_id_inst <= nop_inst; // squash wrong-path fetch
		end else if (!stall) begin
			if_id_pc   <= pc;
			if_id_inst <= inst_in;
		end
	end

	a_pc_hold: assert property (@(posedge clk) disable iff (!arst_n)
		stall && !redirect |=> $stable(pc))
		else $error("pc moved during load stall");

endmodule

/* src/reg_file.sv */
module reg_file
	import cpu_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  reg_addr_t rs,
	input  reg_addr_t rt,
	input  logic      wr_en,
	input  reg_addr_t wr_addr,
	input  word_t     wr_data,
	output word_t     rs_data,
	output word_t     rt_data
);
	word_t regs [4];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			regs <= '{default: '0};
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// writeback bypass into decode
	assign rs_data = (wr_en && wr_addr == rs) ? wr_data : regs[rs];
	assign rt_data = (wr_en && wr_addr == rt) ? wr_data : regs[rt];

	a_wr_addr_known: assert property (@(posedge clk) disable iff (!arst_n)
		wr_en |-> !$isunknown(wr_addr))
		else $error("register write with unknown address");

endmodule

/* src/alu.sv */
module alu
	import cpu_pkg::*;
(
	input  word_t   a,
	input  word_t   b,
	input  alu_op_t op,
	output logic    equal,
	output word_t   result
);

	always_comb begin
		case (op)
			alu_add: result = a + b;
			alu_sub: result = a - b;
			alu_and: result = a & b;
			alu_or:  result = a | b;
			alu_lhi: result = {b[7:0], 8'h00}; // immediate into the upper byte
			default: result = '0;
		endcase
	end

	assign equal = (a == b); // branch condition

endmodule

/* src/pipe_reg.sv */
module pipe_reg
	import cpu_pkg::*;
#(
	parameter type      payload_t = word_t,
	parameter payload_t bubble    = payload_t'(0)
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     flush,
	input  logic     hold,
	input  payload_t d,
	output payload_t q
);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			q <= bubble;
		end else if (flush) begin
			q <= bubble;
		end else if (!hold) begin
			q <= d;
		end
	end

endmodule

/* src/cpu_pkg.sv */
package cpu_pkg;

	localparam int word_w = 16;

	typedef logic [word_w-1:0] word_t;
	typedef logic [1:0]        reg_addr_t;
	typedef logic [3:0]        opcode_t;

	// instruction fields
	localparam int op_lsb = 12;
	localparam int rs_lsb = 10;
	localparam int rt_lsb = 8;
	localparam int rd_lsb = 6;
	localparam int fn_w   = 6;
	localparam int imm_w  = 8;

	localparam opcode_t op_bne = 4'd0;
	localparam opcode_t op_beq = 4'd1;
	localparam opcode_t op_adi = 4'd4;
	localparam opcode_t op_ori = 4'd5;
	localparam opcode_t op_lhi = 4'd6;
	localparam opcode_t op_lwd = 4'd7;
	localparam opcode_t op_swd = 4'd8;
	localparam opcode_t op_nop = 4'd13;
	localparam opcode_t op_alu = 4'd15; // R-type, function code selects

	localparam logic [fn_w-1:0] fn_add = 6'd0;
	localparam logic [fn_w-1:0] fn_sub = 6'd1;
	localparam logic [fn_w-1:0] fn_and = 6'd2;
	localparam logic [fn_w-1:0] fn_orr = 6'd3;
	localparam logic [fn_w-1:0] fn_wwd = 6'd28;
	localparam logic [fn_w-1:0] fn_hlt = 6'd29;

	localparam word_t nop_inst = 16'hd000; // bubble word

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_lhi
	} alu_op_t;

	typedef struct packed {
		word_t     pc;
		reg_addr_t rs;
		reg_addr_t rt;
		word_t     rs_data;
		word_t     rt_data;
		word_t     imm;
		reg_addr_t dest;
		alu_op_t   alu_op;
		logic      alu_src;
		logic      is_branch;
		logic      branch_on_eq;
		logic      mem_read;
		logic      mem_write;
		logic      reg_write;
		logic      is_wwd;
		logic      is_hlt;
		logic      valid;
	} id_ex_t;

	typedef struct packed {
		word_t     alu_result;
		word_t     store_data;
		word_t     wwd_value;
		reg_addr_t dest;
		logic      branch_taken;
		word_t     branch_target;
		logic      mem_read;
		logic      mem_write;
		logic      reg_write;
		logic      is_wwd;
		logic      is_hlt;
		logic      valid;
	} ex_mem_t;

	typedef struct packed {
		word_t     alu_result;
		word_t     load_data;
		word_t     wwd_value;
		reg_addr_t dest;
		logic      mem_to_reg;
		logic      reg_write;
		logic      is_wwd;
		logic      is_hlt;
		logic      valid;
	} mem_wb_t;

	localparam id_ex_t  id_ex_bubble  = id_ex_t'(0);
	localparam ex_mem_t ex_mem_bubble = ex_mem_t'(0);
	localparam mem_wb_t mem_wb_bubble = mem_wb_t'(0);

endpackage
